//--- Bender.yml
package:
  name: ic_interconnect

sources:
  - files:
      - hw/ic_pkg.sv
      - hw/ic_router.sv
      - hw/ic_xbar.sv
      - hw/ic_arbiter.sv
      - hw/ic_interconnect.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_interconnect.sv

//--- files.f
+incdir+verif
hw/ic_pkg.sv
hw/ic_router.sv
hw/ic_xbar.sv
hw/ic_arbiter.sv
hw/ic_interconnect.sv
verif/tb_interconnect.sv

//--- hw/ic_arbiter.sv
`timescale 1ns/1ps

module ic_arbiter #(
  parameter int NumInputs = ic_pkg::NumEndpoints
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  ic_pkg::data_t        in_data_i [NumInputs],
  input  logic [NumInputs-1:0] in_val_i,
  output logic [NumInputs-1:0] in_rdy_o,

  output ic_pkg::msg_t         out_o,
  output logic                 out_val_o,
  input  logic                 out_rdy_i
);

  // winner of this cycle
  logic          grant_val;
  ic_pkg::addr_t grant_addr;
  ic_pkg::data_t grant_data;

  // output register state
  ic_pkg::msg_t  out_q;
  logic          out_val_q;
  logic          accept;

  // register is free, or empties on this edge
  assign accept = !out_val_q || out_rdy_i;

  // ==========================================================================
  // fixed priority, lowest index wins
  // ==========================================================================

  always_comb begin
    grant_val  = 1'b0;
    grant_addr = '0;
    grant_data = '0;
    // walk down so the lowest valid index is the last one written
    for (int i = NumInputs - 1; i >= 0; i--) begin
      if (in_val_i[i]) begin
        grant_val  = 1'b1;
        grant_addr = ic_pkg::addr_t'(i);
        grant_data = in_data_i[i];
      end
    end
  end

  // rdy does not look at the input's own val
  always_comb begin
    logic blocked;
    blocked = 1'b0;
    for (int i = 0; i < NumInputs; i++) begin
      in_rdy_o[i] = accept && !blocked;
      blocked     = blocked | in_val_i[i];
    end
  end

  // ==========================================================================
  // one-entry output register
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_val_q <= 1'b0;
    end else if (accept) begin
      out_val_q <= grant_val;
    end
  end

  // payload, tagged with the source index as its address
  always_ff @(posedge clk_i) begin
    if (accept && grant_val) begin
      out_q.addr <= grant_addr;
      out_q.data <= grant_data;
    end
  end

  assign out_o     = out_q;
  assign out_val_o = out_val_q;

endmodule

//--- hw/ic_interconnect.sv
`timescale 1ns/1ps

module ic_interconnect #(
  parameter int NumEndpoints = ic_pkg::NumEndpoints
) (
  input  logic         clk_i,
  input  logic         arst_n_i,

  // request stream
  input  ic_pkg::msg_t in_i,
  input  logic         in_val_i,
  output logic         in_rdy_o,

  // reply stream
  output ic_pkg::msg_t out_o,
  output logic         out_val_o,
  input  logic         out_rdy_i
);

  // router side
  ic_pkg::data_word_u        rtr_data;
  logic [NumEndpoints-1:0]   rtr_val;
  logic [NumEndpoints-1:0]   rtr_rdy;

  // arbiter side
  ic_pkg::data_t             arb_data [NumEndpoints];
  logic [NumEndpoints-1:0]   arb_val;
  logic [NumEndpoints-1:0]   arb_rdy;

  // crossbar
  ic_pkg::data_t             xbar_in_data [2];
  logic [1:0]                xbar_in_val;
  logic [1:0]                xbar_in_rdy;
  ic_pkg::xbar_ctrl_t        xbar_ctrl;
  logic                      xbar_ctrl_val;
  logic                      xbar_ctrl_rdy;
  ic_pkg::data_t             xbar_out_data [2];
  logic [1:0]                xbar_out_val;
  logic [1:0]                xbar_out_rdy;

  ic_router #(
    .NumOutputs (NumEndpoints)
  ) u_router (
    .in_i       (in_i),
    .in_val_i   (in_val_i),
    .in_rdy_o   (in_rdy_o),
    .out_data_o (rtr_data),
    .out_val_o  (rtr_val),
    .out_rdy_i  (rtr_rdy)
  );

  ic_xbar u_xbar (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_data_i  (xbar_in_data),
    .in_val_i   (xbar_in_val),
    .in_rdy_o   (xbar_in_rdy),
    .ctrl_i     (xbar_ctrl),
    .ctrl_val_i (xbar_ctrl_val),
    .ctrl_rdy_o (xbar_ctrl_rdy),
    .out_data_o (xbar_out_data),
    .out_val_o  (xbar_out_val),
    .out_rdy_i  (xbar_out_rdy)
  );

  ic_arbiter #(
    .NumInputs (NumEndpoints)
  ) u_arbiter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .in_data_i (arb_data),
    .in_val_i  (arb_val),
    .in_rdy_o  (arb_rdy),
    .out_o     (out_o),
    .out_val_o (out_val_o),
    .out_rdy_i (out_rdy_i)
  );

  // ==========================================================================
  // endpoint map
  // ==========================================================================

  // addresses 0 and 2 inject into the crossbar, its outputs answer on 0 and 2
  assign xbar_in_data[0] = rtr_data.data;
  assign xbar_in_data[1] = rtr_data.data;
  assign xbar_in_val     = {rtr_val[ic_pkg::AddrXbarIn1], rtr_val[ic_pkg::AddrXbarIn0]};
  assign xbar_out_rdy    = {arb_rdy[ic_pkg::AddrXbarIn1], arb_rdy[ic_pkg::AddrXbarIn0]};

  // address 1 carries a control word
  assign xbar_ctrl     = rtr_data.ctrl;
  assign xbar_ctrl_val = rtr_val[ic_pkg::AddrXbarCfg];

  for (genvar i = 0; i < NumEndpoints; i++) begin : g_map
    if (i == ic_pkg::AddrXbarIn0) begin : g_in0
      assign rtr_rdy[i]  = xbar_in_rdy[0];
      assign arb_data[i] = xbar_out_data[0];
      assign arb_val[i]  = xbar_out_val[0];
    end else if (i == ic_pkg::AddrXbarCfg) begin : g_cfg
      assign rtr_rdy[i]  = xbar_ctrl_rdy;
      assign arb_data[i] = '0;
      assign arb_val[i]  = 1'b0;
    end else if (i == ic_pkg::AddrXbarIn1) begin : g_in1
      assign rtr_rdy[i]  = xbar_in_rdy[1];
      assign arb_data[i] = xbar_out_data[1];
      assign arb_val[i]  = xbar_out_val[1];
    end else if (i == ic_pkg::AddrLoopback) begin : g_loop
      // straight back into the arbiter
      assign rtr_rdy[i]  = arb_rdy[i];
      assign arb_data[i] = rtr_data.data;
      assign arb_val[i]  = rtr_val[i];
    end else begin : g_unmapped
      // never ready, so these words stall at the input
      assign rtr_rdy[i]  = 1'b0;
      assign arb_data[i] = '0;
      assign arb_val[i]  = 1'b0;
    end
  end

endmodule

//--- hw/ic_pkg.sv
package ic_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  localparam int AddrBits = 4;
  localparam int DataBits = 16;

  // one router output and one arbiter input per address
  localparam int NumEndpoints = 1 << AddrBits;

  typedef logic [AddrBits-1:0] addr_t;
  typedef logic [DataBits-1:0] data_t;

  // ==========================================================================
  // stream and control words
  // ==========================================================================

  // address sits in the upper bits, data below
  typedef struct packed {
    addr_t addr;
    data_t data;
  } msg_t;

  // crossbar control, only the two low bits matter
  typedef struct packed {
    logic [DataBits-3:0] unused;
    logic                in_sel;
    logic                out_sel;
  } xbar_ctrl_t;

  // router payload, read as control on the config address
  typedef union packed {
    data_t      data;
    xbar_ctrl_t ctrl;
  } data_word_u;

  // ==========================================================================
  // endpoint map
  // ==========================================================================

  localparam addr_t AddrXbarIn0  = 4'd0;
  localparam addr_t AddrXbarCfg  = 4'd1;
  localparam addr_t AddrXbarIn1  = 4'd2;
  localparam addr_t AddrLoopback = 4'd9;

endpackage

//--- hw/ic_router.sv
`timescale 1ns/1ps

module ic_router #(
  parameter int NumOutputs = ic_pkg::NumEndpoints
) (
  input  ic_pkg::msg_t       in_i,
  input  logic               in_val_i,
  output logic               in_rdy_o,
  output ic_pkg::data_word_u out_data_o,
  output logic [NumOutputs-1:0] out_val_o,
  input  logic [NumOutputs-1:0] out_rdy_i
);

  // one-hot match of the incoming address
  logic [NumOutputs-1:0] addr_hit;

  // ==========================================================================
  // address decode
  // ==========================================================================

  for (genvar i = 0; i < NumOutputs; i++) begin : g_decode
    assign addr_hit[i] = (in_i.addr == ic_pkg::addr_t'(i));
  end

  // only the addressed endpoint sees val
  assign out_val_o = addr_hit & {NumOutputs{in_val_i}};

  // payload goes to every endpoint, each picks its own view of the union
  assign out_data_o.data = in_i.data;

  // ready comes back from the addressed endpoint only,
  // an address without a match reads as not ready
  assign in_rdy_o = |(addr_hit & out_rdy_i);

endmodule

//--- hw/ic_xbar.sv
`timescale 1ns/1ps

module ic_xbar (
  input  logic               clk_i,
  input  logic               arst_n_i,

  // data inputs
  input  ic_pkg::data_t      in_data_i [2],
  input  logic [1:0]         in_val_i,
  output logic [1:0]         in_rdy_o,

  // control port
  input  ic_pkg::xbar_ctrl_t ctrl_i,
  input  logic               ctrl_val_i,
  output logic               ctrl_rdy_o,

  // data outputs
  output ic_pkg::data_t      out_data_o [2],
  output logic [1:0]         out_val_o,
  input  logic [1:0]         out_rdy_i
);

  // current routing
  logic in_sel_q;
  logic out_sel_q;

  // ==========================================================================
  // control register
  // ==========================================================================

  // never stalls a config word
  assign ctrl_rdy_o = 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_sel_q  <= 1'b0;
      out_sel_q <= 1'b0;
    end else if (ctrl_val_i && ctrl_rdy_o) begin
      // new routing takes effect next cycle
      in_sel_q  <= ctrl_i.in_sel;
      out_sel_q <= ctrl_i.out_sel;
    end
  end

  // ==========================================================================
  // data path
  // ==========================================================================

  // forward: selected input drives only the selected output
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      out_data_o[o] = in_data_i[in_sel_q];
      out_val_o[o]  = in_val_i[in_sel_q] && (out_sel_q == 1'(o));
    end
  end

  // backward: the unconnected input is held off and keeps its word
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      in_rdy_o[i] = (in_sel_q == 1'(i)) && out_rdy_i[out_sel_q];
    end
  end

endmodule

//--- verif/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

// columns: addr, data, accept, has_out, exp_addr, exp_data
typedef struct packed {
  ic_pkg::addr_t addr;
  ic_pkg::data_t data;
  logic          accept;
  logic          has_out;
  ic_pkg::addr_t exp_addr;
  ic_pkg::data_t exp_data;
} case_t;

localparam int NumCases = 9;

localparam case_t Cases [NumCases] = '{
  // loopback returns the word untouched
  '{ic_pkg::AddrLoopback, 16'hA5A5, 1'b1, 1'b1, ic_pkg::AddrLoopback, 16'hA5A5},
  // default routing, input 0 to output 0
  '{ic_pkg::AddrXbarIn0,  16'h1234, 1'b1, 1'b1, ic_pkg::AddrXbarIn0,  16'h1234},
  '{ic_pkg::AddrXbarIn1,  16'h5678, 1'b0, 1'b0, 4'd0,                 16'h0000},
  // in_sel 1, out_sel 1
  '{ic_pkg::AddrXbarCfg,  16'h0003, 1'b1, 1'b0, 4'd0,                 16'h0000},
  '{ic_pkg::AddrXbarIn1,  16'h9ABC, 1'b1, 1'b1, ic_pkg::AddrXbarIn1,  16'h9ABC},
  '{ic_pkg::AddrXbarIn0,  16'h1111, 1'b0, 1'b0, 4'd0,                 16'h0000},
  // in_sel 1, out_sel 0
  '{ic_pkg::AddrXbarCfg,  16'h0002, 1'b1, 1'b0, 4'd0,                 16'h0000},
  '{ic_pkg::AddrXbarIn1,  16'h2222, 1'b1, 1'b1, ic_pkg::AddrXbarIn0,  16'h2222},
  // unmapped endpoint
  '{4'd5,                 16'h5555, 1'b0, 1'b0, 4'd0,                 16'h0000}
};

`endif

//--- verif/tb_interconnect.sv
`timescale 1ns/1ps

module tb_interconnect;

  `include "tb_cases.svh"

  localparam int WaitLimit = 20;

  logic         clk_i;
  logic         arst_n_i;
  ic_pkg::msg_t in_i;
  logic         in_val_i;
  logic         in_rdy_o;
  ic_pkg::msg_t out_o;
  logic         out_val_o;
  logic         out_rdy_i;

  int errors;
  int tests;
  int passed;

  ic_interconnect #(
    .NumEndpoints (ic_pkg::NumEndpoints)
  ) dut0 (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .in_i      (in_i),
    .in_val_i  (in_val_i),
    .in_rdy_o  (in_rdy_o),
    .out_o     (out_o),
    .out_val_o (out_val_o),
    .out_rdy_i (out_rdy_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  // inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic value_error(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      passed++;
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed", tests, name);
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic check_reset();
    int errs_before;
    errs_before = errors;
    for (int n = 0; n < 16; n++) begin
      @(posedge clk_i);
      #1;
      if (out_val_o !== 1'b0) begin
        value_error("out_val_o", 0, out_val_o);
      end
    end
    arst_n_i = 1'b1;
    // first clock edge out of reset
    @(posedge clk_i);
    @(negedge clk_i);
    if (out_val_o !== 1'b0) begin
      value_error("out_val_o", 0, out_val_o);
    end
    finish_test("reset state", errs_before);
  endtask

  task automatic run_row(input int idx);
    int   n;
    int   errs_before;
    logic accepted;
    logic got_out;
    errs_before = errors;
    step_cycle();
    in_i.addr = Cases[idx].addr;
    in_i.data = Cases[idx].data;
    in_val_i  = 1'b1;
    accepted  = 1'b0;
    n = 0;
    while (!accepted && n < WaitLimit) begin
      @(negedge clk_i);
      if (in_rdy_o) begin
        accepted = 1'b1;
      end else if (!Cases[idx].accept && out_val_o !== 1'b0) begin
        value_error("out_val_o", 0, out_val_o);
      end
      n++;
    end
    step_cycle();
    in_val_i = 1'b0;
    if (accepted != Cases[idx].accept) begin
      if (Cases[idx].accept) begin
        $display("row %0d: timeout waiting for in_rdy_o to rise", idx);
      end else begin
        $display("row %0d: word to address %0d was accepted but should stall",
                 idx, Cases[idx].addr);
      end
      errors++;
    end else if (accepted && Cases[idx].has_out) begin
      got_out = 1'b0;
      n = 0;
      while (!got_out && n < WaitLimit) begin
        @(negedge clk_i);
        got_out = (out_val_o === 1'b1);
        n++;
      end
      if (!got_out) begin
        $display("row %0d: timeout waiting for out_val_o to rise", idx);
        errors++;
      end else begin
        if (out_o.addr !== Cases[idx].exp_addr) begin
          value_error("out_o.addr", Cases[idx].exp_addr, out_o.addr);
        end
        if (out_o.data !== Cases[idx].exp_data) begin
          value_error("out_o.data", Cases[idx].exp_data, out_o.data);
        end
      end
    end else if (accepted) begin
      // config words produce no reply
      @(negedge clk_i);
      if (out_val_o !== 1'b0) begin
        value_error("out_val_o", 0, out_val_o);
      end
    end
    finish_test($sformatf("row %0d addr %0d", idx, Cases[idx].addr), errs_before);
  endtask

  task automatic check_backpressure();
    int           n;
    int           errs_before;
    logic         seen;
    ic_pkg::msg_t first;
    ic_pkg::msg_t second;
    errs_before = errors;
    first  = '{addr: ic_pkg::AddrLoopback, data: 16'hBEEF};
    second = '{addr: ic_pkg::AddrLoopback, data: 16'hC0DE};
    step_cycle();
    out_rdy_i = 1'b0;
    in_i      = first;
    in_val_i  = 1'b1;
    seen = 1'b0;
    n = 0;
    while (!seen && n < WaitLimit) begin
      @(negedge clk_i);
      seen = (in_rdy_o === 1'b1);
      n++;
    end
    if (!seen) begin
      $display("back-pressure: timeout waiting for the first word to be accepted");
      errors++;
    end
    step_cycle();
    in_i = second;
    // register full and stalled, so the second word must wait
    for (n = 0; n < 10; n++) begin
      @(negedge clk_i);
      if (out_val_o !== 1'b1) begin
        value_error("out_val_o", 1, out_val_o);
      end
      if (out_o !== first) begin
        value_error("out_o", first, out_o);
      end
      if (in_rdy_o !== 1'b0) begin
        value_error("in_rdy_o", 0, in_rdy_o);
      end
    end
    step_cycle();
    out_rdy_i = 1'b1;
    @(negedge clk_i);
    if (out_o !== first) begin
      value_error("out_o", first, out_o);
    end
    if (in_rdy_o !== 1'b1) begin
      value_error("in_rdy_o", 1, in_rdy_o);
    end
    step_cycle();
    in_val_i = 1'b0;
    seen = 1'b0;
    n = 0;
    while (!seen && n < WaitLimit) begin
      @(negedge clk_i);
      seen = (out_val_o === 1'b1);
      n++;
    end
    if (!seen) begin
      $display("back-pressure: timeout waiting for the second word on out_o");
      errors++;
    end else if (out_o !== second) begin
      value_error("out_o", second, out_o);
    end
    finish_test("back-pressure", errs_before);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    errors    = 0;
    tests     = 0;
    passed    = 0;
    arst_n_i  = 1'b0;
    in_i      = '0;
    in_val_i  = 1'b0;
    out_rdy_i = 1'b1;

    check_reset();
    for (int i = 0; i < NumCases; i++) begin
      run_row(i);
    end
    check_backpressure();
    step_cycle();

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests, passed, tests - passed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
